// File: dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// address and data word widths
`define DCACHE_ADDR_W 32
`define DCACHE_DATA_W 32

// tag is bits 31..12, index bits 11..5 and byte offset bits 4..0
`define DCACHE_TAG_W 20
`define DCACHE_INDEX_W 7
`define DCACHE_OFFSET_W 5

// line geometry
`define DCACHE_SETS 128
`define DCACHE_WORDS 8
`define DCACHE_LINE_W 256

// associativity
`define DCACHE_WAYS 2

`endif

// File: dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
    typedef logic [`DCACHE_DATA_W-1:0] word_t;
    typedef logic [`DCACHE_TAG_W-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    // word number inside a line from address bits 4..2
    typedef logic [`DCACHE_OFFSET_W-3:0] word_sel_t;
    typedef logic [`DCACHE_DATA_W/8-1:0] strb_t;
    // word 0 sits in the low bits
    typedef logic [`DCACHE_LINE_W-1:0] line_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;

    // op high means store
    typedef struct packed {
        logic  op;
        addr_t addr;
        strb_t wstrb;
        word_t wdata;
    } core_req_t;

    typedef struct packed {
        logic  data_ok;
        word_t rdata;
    } core_resp_t;

    typedef struct packed {
        logic idle;
        logic hit;
        logic miss;
    } cache_status_t;

    // memory always moves whole lines
    typedef struct packed {
        logic  rd_req;
        addr_t rd_addr;
        logic  wr_req;
        addr_t wr_addr;
        line_t wr_data;
    } mem_req_t;

    typedef struct packed {
        logic  rd_rdy;
        logic  wr_rdy;
        logic  ret_valid;
        logic  ret_last;
        word_t ret_data;
    } mem_resp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        WRITE
    } cache_state_t;

endpackage

// File: dcache_req_capture.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_req_capture (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  logic                  addr_ok,
    input  dcache_pkg::core_req_t req,
    output dcache_pkg::core_req_t held,
    output dcache_pkg::index_t    read_index
);

    dcache_pkg::index_t in_index;
    dcache_pkg::index_t held_index;

    assign in_index   = req.addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign held_index = held.addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];

    // request is taken at the edge where addr_ok is high
    always_ff @(posedge clk) begin
        if (addr_ok) begin
            held <= req;
        end
    end

    // new set while accepting, else keep the set of the request in flight
    assign read_index = addr_ok ? in_index : held_index;

    // core must hold its request until the cache takes it
    a_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        (req_valid && !addr_ok) |=> $stable(req)
    );

endmodule

// File: dcache_store.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_store (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_pkg::index_t     read_index,
    output dcache_pkg::tag_t       tag_rd [`DCACHE_WAYS],
    output logic [`DCACHE_WAYS-1:0] valid_rd,
    output dcache_pkg::line_t      line_rd [`DCACHE_WAYS],
    input  logic                   wr_en,
    input  dcache_pkg::way_t       wr_way,
    input  dcache_pkg::index_t     wr_index,
    input  dcache_pkg::tag_t       wr_tag,
    input  dcache_pkg::line_t      wr_line
);

    dcache_pkg::tag_t  tag_mem  [`DCACHE_WAYS][`DCACHE_SETS];
    dcache_pkg::line_t data_mem [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] valid_bits;

    // tag and line arrays with synchronous read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][wr_index]  <= wr_tag;
            data_mem[wr_way][wr_index] <= wr_line;
        end
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            tag_rd[w]  <= tag_mem[w][read_index];
            line_rd[w] <= data_mem[w][read_index];
        end
    end

    // valid bits cleared for every set on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            valid_rd   <= '0;
        end else begin
            if (wr_en) begin
                valid_bits[wr_way][wr_index] <= 1'b1;
            end
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid_rd[w] <= valid_bits[w][read_index];
            end
        end
    end

endmodule

// File: dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    input  dcache_pkg::core_req_t     held,
    output logic                      addr_ok,
    input  dcache_pkg::tag_t          tag_rd [`DCACHE_WAYS],
    input  logic [`DCACHE_WAYS-1:0]   valid_rd,
    input  dcache_pkg::line_t         line_rd [`DCACHE_WAYS],
    output logic                      wr_en,
    output dcache_pkg::way_t          wr_way,
    output dcache_pkg::index_t        wr_index,
    output dcache_pkg::tag_t          wr_tag,
    output dcache_pkg::line_t         wr_line,
    output logic                      miss_start,
    output logic                      write_back,
    output dcache_pkg::addr_t         fill_addr,
    output dcache_pkg::addr_t         victim_addr,
    output dcache_pkg::line_t         victim_line,
    input  logic                      req_sent,
    input  logic                      line_done,
    input  dcache_pkg::line_t         fill_line,
    output dcache_pkg::core_resp_t    resp,
    output dcache_pkg::cache_status_t status
);

    dcache_pkg::cache_state_t state, next_state;
    dcache_pkg::tag_t      req_tag;
    dcache_pkg::index_t    req_index;
    dcache_pkg::word_sel_t req_word;
    logic [`DCACHE_WAYS-1:0] hit_vec;
    logic                  hit_any;
    dcache_pkg::way_t      hit_way;
    dcache_pkg::way_t      victim;
    dcache_pkg::line_t     hit_line;
    logic [`DCACHE_SETS-1:0] lru_bits;
    logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] dirty_bits;
    logic                  data_ok_q;
    dcache_pkg::word_t     rdata_q;
    logic                  idle_q;

    // strobed bytes of the held store into one word of a line
    function automatic dcache_pkg::line_t merge_word(input dcache_pkg::line_t line);
        dcache_pkg::line_t merged;
        merged = line;
        for (int b = 0; b < `DCACHE_DATA_W / 8; b++) begin
            if (held.wstrb[b]) begin
                merged[req_word * `DCACHE_DATA_W + b * 8 +: 8] = held.wdata[b * 8 +: 8];
            end
        end
        return merged;
    endfunction

    assign req_tag   = held.addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign req_index = held.addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign req_word  = held.addr[`DCACHE_OFFSET_W-1:2];

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit_vec[w] = valid_rd[w] && (tag_rd[w] == req_tag);
        end
    end

    assign hit_any  = |hit_vec;
    assign hit_way  = dcache_pkg::way_t'(hit_vec[1]);
    assign hit_line = line_rd[hit_way];
    // lru bit of a set names the way to evict next
    assign victim   = lru_bits[req_index];

    assign addr_ok     = req_valid && (state == dcache_pkg::IDLE);
    assign miss_start  = (state == dcache_pkg::LOOKUP) && !hit_any;
    assign write_back  = valid_rd[victim] && dirty_bits[req_index][victim];
    assign fill_addr   = {held.addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], `DCACHE_OFFSET_W'(0)};
    assign victim_addr = {tag_rd[victim], req_index, `DCACHE_OFFSET_W'(0)};
    assign victim_line = line_rd[victim];

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::IDLE:   if (req_valid) next_state = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP: next_state = hit_any ? dcache_pkg::IDLE : dcache_pkg::MISS;
            dcache_pkg::MISS:   if (req_sent) next_state = dcache_pkg::REFILL;
            dcache_pkg::REFILL: if (line_done) next_state = dcache_pkg::WRITE;
            dcache_pkg::WRITE:  next_state = dcache_pkg::IDLE;
            default:            next_state = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // store hit writes in LOOKUP, refill writes the victim in WRITE
    assign wr_index = req_index;
    assign wr_tag   = req_tag;
    always_comb begin
        wr_en   = (state == dcache_pkg::LOOKUP) && hit_any && held.op;
        wr_way  = hit_way;
        wr_line = merge_word(hit_line);
        if (state == dcache_pkg::WRITE) begin
            wr_en   = 1'b1;
            wr_way  = victim;
            wr_line = held.op ? merge_word(fill_line) : fill_line;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_bits   <= '0;
            dirty_bits <= '0;
        end else if (state == dcache_pkg::LOOKUP && hit_any) begin
            lru_bits[req_index] <= ~hit_way;
            if (held.op) begin
                dirty_bits[req_index][hit_way] <= 1'b1;
            end
        end else if (state == dcache_pkg::WRITE) begin
            lru_bits[req_index]           <= ~victim;
            dirty_bits[req_index][victim] <= held.op;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_ok_q <= 1'b0;
            idle_q    <= 1'b0;
        end else begin
            data_ok_q <= ((state == dcache_pkg::LOOKUP) && hit_any) ||
                         (state == dcache_pkg::WRITE);
            idle_q    <= (next_state == dcache_pkg::IDLE);
        end
    end

    // word as it stood before any store merge
    always_ff @(posedge clk) begin
        if (state == dcache_pkg::WRITE) begin
            rdata_q <= fill_line[req_word * `DCACHE_DATA_W +: `DCACHE_DATA_W];
        end else begin
            rdata_q <= hit_line[req_word * `DCACHE_DATA_W +: `DCACHE_DATA_W];
        end
    end

    assign resp   = '{data_ok: data_ok_q, rdata: rdata_q};
    assign status = '{idle: idle_q,
                      hit: (state == dcache_pkg::LOOKUP) && hit_any,
                      miss: miss_start};

    // a tag lives in at most one way of its set
    a_one_way_hit: assert property (
        @(posedge clk) disable iff (reset)
        (state == dcache_pkg::LOOKUP) |-> !(&hit_vec)
    );

    a_data_ok_pulse: assert property (
        @(posedge clk) disable iff (reset)
        data_ok_q |=> !data_ok_q
    );

endmodule

// File: dcache_mem_port.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_mem_port (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  miss_start,
    input  logic                  write_back,
    input  dcache_pkg::addr_t     fill_addr,
    input  dcache_pkg::addr_t     victim_addr,
    input  dcache_pkg::line_t     victim_line,
    output dcache_pkg::mem_req_t  mem_req,
    input  dcache_pkg::mem_resp_t mem_resp,
    output logic                  req_sent,
    output logic                  line_done,
    output dcache_pkg::line_t     fill_line
);

    logic                  rd_req_q;
    logic                  wr_req_q;
    dcache_pkg::addr_t     rd_addr_q;
    dcache_pkg::addr_t     wr_addr_q;
    dcache_pkg::line_t     wr_data_q;
    dcache_pkg::word_sel_t beat_cnt;
    logic                  line_done_q;
    dcache_pkg::line_t     fill_q;

    // request levels held until memory takes them
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_req_q <= 1'b0;
            wr_req_q <= 1'b0;
        end else if (miss_start) begin
            rd_req_q <= 1'b1;
            wr_req_q <= write_back;
        end else begin
            if (rd_req_q && mem_resp.rd_rdy) begin
                rd_req_q <= 1'b0;
            end
            if (wr_req_q && mem_resp.wr_rdy) begin
                wr_req_q <= 1'b0;
            end
        end
    end

    // addresses and victim line latched at miss time
    always_ff @(posedge clk) begin
        if (miss_start) begin
            rd_addr_q <= fill_addr;
            wr_addr_q <= victim_addr;
            wr_data_q <= victim_line;
        end
    end

    // high on the edge where the last pending request goes out
    assign req_sent = (rd_req_q || wr_req_q) &&
                      (!rd_req_q || mem_resp.rd_rdy) &&
                      (!wr_req_q || mem_resp.wr_rdy);

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_cnt    <= '0;
            line_done_q <= 1'b0;
        end else begin
            line_done_q <= mem_resp.ret_valid && mem_resp.ret_last;
            if (mem_resp.ret_valid) begin
                beat_cnt <= mem_resp.ret_last ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    // burst beats land in word order
    always_ff @(posedge clk) begin
        if (mem_resp.ret_valid) begin
            fill_q[beat_cnt * `DCACHE_DATA_W +: `DCACHE_DATA_W] <= mem_resp.ret_data;
        end
    end

    assign line_done = line_done_q;
    assign fill_line = fill_q;
    assign mem_req   = '{rd_req: rd_req_q, rd_addr: rd_addr_q,
                         wr_req: wr_req_q, wr_addr: wr_addr_q, wr_data: wr_data_q};

    // memory only answers a read it has accepted
    a_no_early_beat: assert property (
        @(posedge clk) disable iff (reset)
        mem_resp.ret_valid |-> !rd_req_q
    );

endmodule

// File: dcache_top.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    input  dcache_pkg::core_req_t     req,
    output logic                      addr_ok,
    output dcache_pkg::core_resp_t    resp,
    output dcache_pkg::cache_status_t status,
    output dcache_pkg::mem_req_t      mem_req,
    input  dcache_pkg::mem_resp_t     mem_resp
);

    dcache_pkg::core_req_t   held;
    dcache_pkg::index_t      read_index;
    dcache_pkg::tag_t        tag_rd [`DCACHE_WAYS];
    logic [`DCACHE_WAYS-1:0] valid_rd;
    dcache_pkg::line_t       line_rd [`DCACHE_WAYS];
    logic                    wr_en;
    dcache_pkg::way_t        wr_way;
    dcache_pkg::index_t      wr_index;
    dcache_pkg::tag_t        wr_tag;
    dcache_pkg::line_t       wr_line;
    logic                    miss_start;
    logic                    write_back;
    dcache_pkg::addr_t       fill_addr;
    dcache_pkg::addr_t       victim_addr;
    dcache_pkg::line_t       victim_line;
    logic                    req_sent;
    logic                    line_done;
    dcache_pkg::line_t       fill_line;

    dcache_req_capture capture_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .addr_ok    (addr_ok),
        .req        (req),
        .held       (held),
        .read_index (read_index)
    );

    dcache_store store_i (
        .clk        (clk),
        .reset      (reset),
        .read_index (read_index),
        .tag_rd     (tag_rd),
        .valid_rd   (valid_rd),
        .line_rd    (line_rd),
        .wr_en      (wr_en),
        .wr_way     (wr_way),
        .wr_index   (wr_index),
        .wr_tag     (wr_tag),
        .wr_line    (wr_line)
    );

    dcache_ctrl ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .held        (held),
        .addr_ok     (addr_ok),
        .tag_rd      (tag_rd),
        .valid_rd    (valid_rd),
        .line_rd     (line_rd),
        .wr_en       (wr_en),
        .wr_way      (wr_way),
        .wr_index    (wr_index),
        .wr_tag      (wr_tag),
        .wr_line     (wr_line),
        .miss_start  (miss_start),
        .write_back  (write_back),
        .fill_addr   (fill_addr),
        .victim_addr (victim_addr),
        .victim_line (victim_line),
        .req_sent    (req_sent),
        .line_done   (line_done),
        .fill_line   (fill_line),
        .resp        (resp),
        .status      (status)
    );

    dcache_mem_port mem_port_i (
        .clk         (clk),
        .reset       (reset),
        .miss_start  (miss_start),
        .write_back  (write_back),
        .fill_addr   (fill_addr),
        .victim_addr (victim_addr),
        .victim_line (victim_line),
        .mem_req     (mem_req),
        .mem_resp    (mem_resp),
        .req_sent    (req_sent),
        .line_done   (line_done),
        .fill_line   (fill_line)
    );

endmodule

// File: tb_mem_model.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module tb_mem_model (
    input  logic                  clk,
    input  logic                  reset,
    input  dcache_pkg::mem_req_t  mem_req,
    output dcache_pkg::mem_resp_t mem_resp
);

    localparam int LOG_DEPTH = 16;

    // sparse memory where untouched words read back the fill pattern
    dcache_pkg::word_t mem [dcache_pkg::addr_t];
    dcache_pkg::addr_t wb_addr [LOG_DEPTH];
    dcache_pkg::line_t wb_line [LOG_DEPTH];
    int                wb_count = 0;
    integer            seed = 32'hcdef;
    int                rd_delay = -1;
    int                wr_delay = -1;
    logic              rd_pending = 1'b0;
    int                beat = 0;
    dcache_pkg::addr_t rd_base = '0;
    logic              rd_rdy_q = 1'b0;
    logic              wr_rdy_q = 1'b0;
    logic              ret_valid_q = 1'b0;
    logic              ret_last_q = 1'b0;
    dcache_pkg::word_t ret_data_q = '0;

    function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    // 0 to 3 cycles before ready
    function automatic int draw_delay();
        return int'($unsigned($random(seed)) % 4);
    endfunction

    always @(negedge clk) begin
        if (reset) begin
            rd_rdy_q    <= 1'b0;
            wr_rdy_q    <= 1'b0;
            ret_valid_q <= 1'b0;
            ret_last_q  <= 1'b0;
            rd_delay    = -1;
            wr_delay    = -1;
            rd_pending  = 1'b0;
            beat        = 0;
        end else begin
            // write-back taken at the edge just passed
            if (wr_rdy_q) begin
                for (int w = 0; w < `DCACHE_WORDS; w++) begin
                    mem[mem_req.wr_addr + dcache_pkg::addr_t'(4 * w)] =
                        mem_req.wr_data[w * `DCACHE_DATA_W +: `DCACHE_DATA_W];
                end
                if (wb_count < LOG_DEPTH) begin
                    wb_addr[wb_count] = mem_req.wr_addr;
                    wb_line[wb_count] = mem_req.wr_data;
                end
                wb_count++;
                wr_rdy_q <= 1'b0;
                wr_delay = -1;
            end else if (mem_req.wr_req) begin
                if (wr_delay < 0) begin
                    wr_delay = draw_delay();
                end
                if (wr_delay == 0) begin
                    wr_rdy_q <= 1'b1;
                end else begin
                    wr_delay--;
                end
            end

            if (rd_rdy_q) begin
                rd_pending = 1'b1;
                rd_base    = mem_req.rd_addr;
                beat       = 0;
                rd_rdy_q   <= 1'b0;
                rd_delay   = -1;
            end else if (mem_req.rd_req) begin
                if (rd_delay < 0) begin
                    rd_delay = draw_delay();
                end
                if (rd_delay == 0) begin
                    rd_rdy_q <= 1'b1;
                end else begin
                    rd_delay--;
                end
            end

            // burst starts only once no write-back is pending
            ret_valid_q <= 1'b0;
            ret_last_q  <= 1'b0;
            if (rd_pending && !mem_req.wr_req) begin
                ret_valid_q <= 1'b1;
                ret_data_q  <= read_word(rd_base + dcache_pkg::addr_t'(4 * beat));
                ret_last_q  <= (beat == `DCACHE_WORDS - 1);
                if (beat == `DCACHE_WORDS - 1) begin
                    rd_pending = 1'b0;
                end
                beat++;
            end
        end
    end

    assign mem_resp = '{rd_rdy: rd_rdy_q, wr_rdy: wr_rdy_q, ret_valid: ret_valid_q,
                        ret_last: ret_last_q, ret_data: ret_data_q};

endmodule

// File: tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module tb_dcache;

    localparam int NUM_ROWS = 13;
    localparam int MAX_CYCLES = NUM_ROWS * 40 + 20;

    // one request with its expected answer and write-back
    typedef struct packed {
        logic                  op;
        dcache_pkg::addr_t     addr;
        dcache_pkg::strb_t     wstrb;
        dcache_pkg::word_t     wdata;
        dcache_pkg::word_t     exp_rdata;
        logic                  exp_hit;
        logic                  exp_wb;
        dcache_pkg::addr_t     wb_addr;
        dcache_pkg::word_sel_t wb_sel;
        dcache_pkg::word_t     wb_word;
    } row_t;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      req_valid;
    dcache_pkg::core_req_t     req;
    logic                      addr_ok;
    dcache_pkg::core_resp_t    resp;
    dcache_pkg::cache_status_t status;
    dcache_pkg::mem_req_t      mem_req;
    dcache_pkg::mem_resp_t     mem_resp;

    row_t rows [NUM_ROWS];
    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    int   req_drops = 0;
    logic rd_req_prev = 1'b0;

    dcache_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .resp      (resp),
        .status    (status),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp)
    );

    tb_mem_model mem_i (
        .clk      (clk),
        .reset    (reset),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // rd_req must hold until memory gives rd_rdy
    always @(negedge clk) begin
        if (reset) begin
            rd_req_prev <= 1'b0;
        end else begin
            if (rd_req_prev && !mem_resp.rd_rdy && !mem_req.rd_req) begin
                req_drops++;
                $display("rd_req went low at cycle %0d before rd_rdy was given", cycles);
            end
            rd_req_prev <= mem_req.rd_req;
        end
    end

    task automatic check_word(input string name, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input dcache_pkg::line_t got,
                              input dcache_pkg::line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // initial memory contents
    function automatic dcache_pkg::word_t pattern_word(input dcache_pkg::addr_t a);
        return {a[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    function automatic dcache_pkg::line_t pattern_line(input dcache_pkg::addr_t base);
        dcache_pkg::line_t l;
        for (int w = 0; w < `DCACHE_WORDS; w++) begin
            l[w * `DCACHE_DATA_W +: `DCACHE_DATA_W] =
                pattern_word(base + dcache_pkg::addr_t'(4 * w));
        end
        return l;
    endfunction

    function automatic row_t make_row(
        input logic              op,
        input dcache_pkg::addr_t addr,
        input dcache_pkg::strb_t wstrb,
        input dcache_pkg::word_t wdata,
        input dcache_pkg::word_t exp_rdata,
        input logic              exp_hit
    );
        row_t r;
        r           = '0;
        r.op        = op;
        r.addr      = addr;
        r.wstrb     = wstrb;
        r.wdata     = wdata;
        r.exp_rdata = exp_rdata;
        r.exp_hit   = exp_hit;
        return r;
    endfunction

    // tags 1, 2 and 3 all map to set 3
    // every lru bit starts at way 0
    task automatic load_table();
        rows[0]  = make_row(1'b0, 32'h0000_1064, 4'h0, 32'h0, 32'h5a5a_1064, 1'b0);
        rows[1]  = make_row(1'b0, 32'h0000_107c, 4'h0, 32'h0, 32'h5a5a_107c, 1'b1);
        // bytes 0 and 2 from wdata
        rows[2]  = make_row(1'b1, 32'h0000_1068, 4'b0101, 32'haabb_ccdd, 32'h5a5a_1068, 1'b1);
        rows[3]  = make_row(1'b0, 32'h0000_1068, 4'h0, 32'h0, 32'h5abb_10dd, 1'b1);
        rows[4]  = make_row(1'b0, 32'h0000_2060, 4'h0, 32'h0, 32'h5a5a_2060, 1'b0);
        rows[5]  = make_row(1'b0, 32'h0000_1068, 4'h0, 32'h0, 32'h5abb_10dd, 1'b1);
        // tag 3 replaces the clean tag 2 line
        rows[6]  = make_row(1'b0, 32'h0000_306c, 4'h0, 32'h0, 32'h5a5a_306c, 1'b0);
        rows[7]  = make_row(1'b0, 32'h0000_1060, 4'h0, 32'h0, 32'h5a5a_1060, 1'b1);
        rows[8]  = make_row(1'b0, 32'h0000_2064, 4'h0, 32'h0, 32'h5a5a_2064, 1'b0);
        // dirty tag 1 line goes back to memory
        rows[9]  = make_row(1'b0, 32'h0000_3070, 4'h0, 32'h0, 32'h5a5a_3070, 1'b0);
        rows[9].exp_wb  = 1'b1;
        rows[9].wb_addr = 32'h0000_1060;
        rows[9].wb_sel  = 3'd2;
        rows[9].wb_word = 32'h5abb_10dd;
        rows[10] = make_row(1'b0, 32'h0000_1068, 4'h0, 32'h0, 32'h5abb_10dd, 1'b0);
        // store miss in set 5 taking the upper bytes from wdata
        rows[11] = make_row(1'b1, 32'h0000_40a4, 4'b1100, 32'h1122_3344, 32'h5a5a_40a4, 1'b0);
        rows[12] = make_row(1'b0, 32'h0000_40a4, 4'h0, 32'h0, 32'h1122_40a4, 1'b1);
    endtask

    task automatic check_reset_outputs();
        check_flag("resp.data_ok", resp.data_ok, 1'b0);
        check_flag("mem_req.rd_req", mem_req.rd_req, 1'b0);
        check_flag("mem_req.wr_req", mem_req.wr_req, 1'b0);
        check_flag("status.idle", status.idle, 1'b0);
        check_flag("status.hit", status.hit, 1'b0);
        check_flag("status.miss", status.miss, 1'b0);
        check_flag("addr_ok", addr_ok, 1'b0);
        req_valid = 1'b1;
        #1;
        check_flag("addr_ok", addr_ok, 1'b1);
        @(negedge clk);
        req_valid = 1'b0;
        #1;
        check_flag("addr_ok", addr_ok, 1'b0);
    endtask

    // starts on a falling edge and returns on the one that shows data_ok
    task automatic run_row(input int idx, input row_t r);
        int                wb_before;
        dcache_pkg::line_t exp_line;
        wb_before = mem_i.wb_count;
        req = '{op: r.op, addr: r.addr, wstrb: r.wstrb, wdata: r.wdata};
        req_valid = 1'b1;
        #1;
        while (!addr_ok) begin
            @(negedge clk);
            #1;
        end
        // lookup cycle
        @(negedge clk);
        req_valid = 1'b0;
        check_flag("status.hit", status.hit, r.exp_hit);
        check_flag("status.miss", status.miss, !r.exp_hit);
        check_flag("status.idle", status.idle, 1'b0);
        @(negedge clk);
        if (r.exp_hit) begin
            check_flag("resp.data_ok", resp.data_ok, 1'b1);
        end
        while (!resp.data_ok) begin
            @(negedge clk);
        end
        check_flag("status.idle", status.idle, 1'b1);
        if (!r.op) begin
            check_word("resp.rdata", resp.rdata, r.exp_rdata);
        end
        if (mem_i.wb_count != wb_before + int'(r.exp_wb)) begin
            errors++;
            $display("row %0d: memory logged %0d write-backs, expected %0d",
                     idx, mem_i.wb_count - wb_before, r.exp_wb);
        end else if (r.exp_wb) begin
            exp_line = pattern_line(r.wb_addr);
            exp_line[r.wb_sel * `DCACHE_DATA_W +: `DCACHE_DATA_W] = r.wb_word;
            check_word("mem_req.wr_addr", mem_i.wb_addr[wb_before], r.wb_addr);
            check_line("mem_req.wr_data", mem_i.wb_line[wb_before], exp_line);
        end
    endtask

    initial begin
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        load_table();
        repeat (2) @(negedge clk);
        check_reset_outputs();
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i, rows[i]);
        end
        $display("%0d checks, %0d errors, %0d rd_req drops", checks, errors, req_drops);
        if (errors == 0 && req_drops == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+.
dcache_pkg.sv
dcache_req_capture.sv
dcache_store.sv
dcache_ctrl.sv
dcache_mem_port.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
